//--- Bender.yml
package:
  name: vsa_system

sources:
  # packages first, then the design bottom-up
  - hdl/isaPkg.sv
  - hdl/busPkg.sv
  - hdl/regFile.sv
  - hdl/aluUnit.sv
  - hdl/vsaCore.sv
  - hdl/apbMaster.sv
  - hdl/vsaSystem.sv
  - target: test
    files:
      - bench/vsaTbMem.sv
      - bench/vsaTb.sv

//--- bench/vsaTb.sv
// testbench top for the processor system
// program, reference ISA model, concurrent checks, watchdog and report
`timescale 1ns/1ps
`default_nettype none

module vsaTb;

    localparam int PROG_LEN   = 38;
    localparam int HALT_IDX   = 37;
    localparam int TIMEOUT_NS = PROG_LEN * 10 * 4 + 40 + 500; // program, reset, margin

    logic clock;
    logic rst;
    logic [11:0] pc;
    logic [15:0] instruction;
    logic [15:0] paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic psel;
    logic penable;
    logic pwrite;
    logic pready;

    // reference model state
    logic [15:0] refReg [0:3];
    logic [15:0] refMem [0:63];
    logic [11:0] expPc;
    logic        expMem;
    logic        expWrite;
    logic [15:0] expAddr;
    logic [15:0] expWdata;
    logic [12:0] lastPc = 13'h1000; // no pc seen yet
    int steps = 0;
    int gap = 0;
    int errors = 0;
    int testIdx = 0;
    int errStart = 0;
    bit haltSeen = 0;
    int    bound [0:4] = '{14, 22, 26, 31, 37}; // first word of the next test
    string names [0:5] = '{"register ALU ops", "immediates", "loads with wait states",
                           "branches", "R0 and no-ops", "reset and timing"};

    vsaSystem i_vsaSystem (.clock(clock), .rst(rst), .pc(pc), .instruction(instruction),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready));

    vsaTbMem memModel (.clock(clock), .rst(rst), .pc(pc), .instruction(instruction),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready));

    function automatic logic [15:0] rInstr(logic [6:0] fn, logic [1:0] s1, s2, d);
        return {isaPkg::OP_ALUOP, s1, s2, d, fn};
    endfunction

    function automatic logic [15:0] iInstr(logic [2:0] op, logic [1:0] s1, d, logic [8:0] imm);
        return {op, s1, d, imm};
    endfunction

    task automatic loadProgram();
        logic [15:0] p [0:PROG_LEN-1];
        p = '{iInstr(0, 0, 1, 0), iInstr(0, 0, 2, 2),        // R1, R2 from memory
              rInstr(isaPkg::FN_ADD, 1, 2, 3), iInstr(1, 0, 3, 64),
              rInstr(isaPkg::FN_SUB, 1, 2, 3), iInstr(1, 0, 3, 66),
              rInstr(isaPkg::FN_AND, 1, 2, 3), iInstr(1, 0, 3, 68),
              rInstr(isaPkg::FN_OR, 1, 2, 3), iInstr(1, 0, 3, 70),
              rInstr(isaPkg::FN_XOR, 1, 2, 3), iInstr(1, 0, 3, 72),
              rInstr(isaPkg::FN_SRL, 1, 2, 3), iInstr(1, 0, 3, 74),
              iInstr(4, 1, 3, 100), iInstr(1, 0, 3, 76),      // addi +100
              iInstr(4, 1, 3, 9'h1fd), iInstr(1, 0, 3, 78),   // addi -3
              iInstr(5, 2, 3, 9'h1f9), iInstr(1, 0, 3, 80),   // subi -7
              iInstr(5, 2, 3, 200), iInstr(1, 0, 3, 82),
              iInstr(0, 0, 1, 20), iInstr(1, 0, 1, 84),
              iInstr(0, 0, 2, 40), iInstr(1, 0, 2, 86),
              iInstr(2, 0, 0, 1), iInstr(4, 0, 3, 1),         // taken, skips addi
              iInstr(2, 1, 0, 1), iInstr(4, 0, 3, 5),         // not taken
              iInstr(1, 0, 3, 88),
              iInstr(4, 1, 0, 7), iInstr(1, 0, 0, 90),        // write to R0 dropped
              16'hefff, iInstr(1, 0, 3, 92),                  // opcode 7 with src R1, dest R3
              rInstr(7'd99, 1, 2, 3), iInstr(1, 0, 3, 94),    // unused funct
              iInstr(2, 0, 0, 9'h1ff)};                       // halt, branch to self
        for (int i = 0; i < PROG_LEN; i++) memModel.prog[i] = p[i];
    endtask

    // one instruction of the ISA, from the rules of the instruction set
    task automatic stepModel(logic [11:0] curPc);
        logic [15:0] w, a, b, ext, res, addr;
        logic [2:0]  op;
        w   = memModel.prog[curPc[6:1]];
        op  = w[15:13];
        a   = refReg[w[12:11]];
        b   = refReg[w[10:9]];
        ext = {{8{w[8]}}, w[7:0]};
        addr = a + ext;
        expPc  = curPc + 12'd2;
        expMem = (op == 0) || (op == 1);
        expWrite = (op == 1);
        expAddr  = addr;
        expWdata = b;
        if (steps == 0) begin
            for (int i = 0; i < 64; i++) refMem[i] = memModel.dataMem[i]; // initial image
        end
        case (op)
            0: if (w[10:9] != 0) refReg[w[10:9]] = refMem[addr[6:1]];
            1: refMem[addr[6:1]] = b;
            2: if (a == 0) expPc = curPc + 12'd2 + {ext[10:0], 1'b0};
            3: begin
                case (w[6:0])
                    0: res = a + b;
                    1: res = a - b;
                    2: res = a & b;
                    3: res = a | b;
                    4: res = a ^ b;
                    5: res = a >> 1;
                    default: res = 'x;
                endcase
                if (w[6:0] <= 5 && w[8:7] != 0) refReg[w[8:7]] = res;
            end
            4: if (w[10:9] != 0) refReg[w[10:9]] = a + ext;
            5: if (w[10:9] != 0) refReg[w[10:9]] = a - ext;
            default: ; // no-op
        endcase
        steps++;
        if (testIdx < 5 && curPc[11:1] >= bound[testIdx]) finishTest();
        if (curPc[11:1] == HALT_IDX) haltSeen = 1;
    endtask

    task automatic finishTest();
        $display("test %0d %s done, %0d errors", testIdx + 1, names[testIdx], errors - errStart);
        errStart = errors;
        testIdx++;
    endtask

    initial begin
        clock = 0;
        forever #2 clock = ~clock;
    end

    // model steps on the first cycle a new pc is visible
    always @(posedge clock) begin
        if (!rst && {1'b0, pc} != lastPc) begin
            lastPc <= {1'b0, pc};
            gap    <= 1;
            stepModel(pc);
        end else begin
            gap <= gap + 1;
        end
    end

    // bus protocol
    penWithSel: assert property (@(posedge clock) penable |-> psel)
        else begin
            errors++;
            $display("penable high without psel");
        end
    holdStable: assert property (@(posedge clock) disable iff (rst)
        psel && penable && !pready |=> $stable(paddr) && $stable(pwrite) && $stable(pwdata))
        else begin
            errors++;
            $display("APB signals changed during a wait state");
        end
    // predicted transfers
    xferExpected: assert property (@(posedge clock) disable iff (rst)
        psel && penable && pready |-> expMem)
        else begin
            errors++;
            $display("APB transfer from a non-memory instruction");
        end
    paddrCheck: assert property (@(posedge clock) disable iff (rst)
        psel && penable && pready |-> paddr == expAddr && pwrite == expWrite)
        else begin
            errors++;
            $display("CHECK FAILED paddr/pwrite: got %h/%h, expected %h/%h",
                $sampled(paddr), $sampled(pwrite), $sampled(expAddr), $sampled(expWrite));
        end
    pwdataCheck: assert property (@(posedge clock) disable iff (rst)
        psel && penable && pready && pwrite |-> pwdata == expWdata)
        else begin
            errors++;
            $display("CHECK FAILED pwdata: got %h, expected %h",
                $sampled(pwdata), $sampled(expWdata));
        end
    // pc sequence
    pcCheck: assert property (@(posedge clock) disable iff (rst)
        $changed(pc) && steps > 0 |-> pc == expPc)
        else begin
            errors++;
            $display("CHECK FAILED pc: got %h, expected %h", $sampled(pc), $sampled(expPc));
        end
    pcEven: assert property (@(posedge clock) disable iff (rst) pc[0] == 1'b0)
        else begin
            errors++;
            $display("CHECK FAILED pc: odd value %h", $sampled(pc));
        end
    fiveCycles: assert property (@(posedge clock) disable iff (rst)
        $changed(pc) && steps > 1 && !expMem |-> gap == 5)
        else begin
            errors++;
            $display("CHECK FAILED pc gap: got %h cycles, expected %h", $sampled(gap), 5);
        end
    // reset state, every cycle after a reset edge, so also the cycle after release
    resetState: assert property (@(posedge clock) $past(rst) |-> pc == 0 && !psel && !penable)
        else begin
            errors++;
            $display("pc or APB select not idle around reset");
        end

    initial begin
        void'($urandom(32'hba3f_48f9));
        rst = 1'b1;
        for (int i = 0; i < 4; i++) refReg[i] = '0;
        @(posedge clock);
        loadProgram(); // over the default fill of the memory model
        repeat (9) @(posedge clock);
        rst <= 1'b0;
        wait (haltSeen);
        repeat (12) @(posedge clock);
        finishTest();
        $display("tests run: %0d, checks failed: %0d", testIdx, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the program never reached its halt instruction");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/vsaTbMem.sv
// testbench memory model
// instruction ROM indexed by pc, APB slave over 64 data words with random wait states
`timescale 1ns/1ps
`default_nettype none

module vsaTbMem (
    input  wire logic                          clock,
    input  wire logic                          rst,
    input  wire logic [isaPkg::PC_WIDTH-1:0]   pc,
    output      logic [busPkg::DATA_WIDTH-1:0] instruction,
    input  wire logic [busPkg::ADDR_WIDTH-1:0] paddr,
    input  wire logic                          psel,
    input  wire logic                          penable,
    input  wire logic                          pwrite,
    input  wire logic [busPkg::DATA_WIDTH-1:0] pwdata,
    output      logic [busPkg::DATA_WIDTH-1:0] prdata,
    output      logic                          pready
);

    logic [15:0] prog [0:63];    // filled by the testbench top
    logic [15:0] dataMem [0:63]; // word array, byte address bits 6:1
    int          waitLeft;       // access cycles still to stall
    int          waitDraw;

    initial begin
        instruction = '0;
        prdata      = '0;
        pready      = 1'b0;
        waitLeft    = 0;
        for (int i = 0; i < 64; i++) begin
            prog[i]    = 16'he000 | 16'(i);            // opcode 7 no-op, index in low bits
            dataMem[i] = 16'(i * 16'h0b17) ^ 16'h3c5a; // every address differs
        end
    end

    // fetch word follows pc one cycle later, core samples it in IF
    always @(posedge clock) begin
        instruction <= prog[pc[6:1]];
    end

    // APB slave
    always @(posedge clock) begin
        if (rst) begin
            pready   <= 1'b0;
            waitLeft <= 0;
        end else if (psel && !penable) begin
            waitDraw = $urandom % 4; // 0..3 wait states
            if (waitDraw == 0) begin
                pready <= 1'b1;
                prdata <= dataMem[paddr[6:1]];
                if (pwrite) dataMem[paddr[6:1]] <= pwdata;
            end else begin
                waitLeft <= waitDraw - 1;
                pready   <= 1'b0;
            end
        end else if (psel && penable) begin
            if (pready) begin
                pready <= 1'b0; // transfer ended this cycle
            end else if (waitLeft == 0) begin
                pready <= 1'b1;
                prdata <= dataMem[paddr[6:1]];
                if (pwrite) dataMem[paddr[6:1]] <= pwdata;
            end else begin
                waitLeft <= waitLeft - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/aluUnit.sv
// combinational ALU of the core
// register and immediate operations, load/store address,
// branch target and zero test of operand A
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  wire isaPkg::aluOp                  op,
    input  wire logic [busPkg::DATA_WIDTH-1:0] operandA,
    input  wire logic [busPkg::DATA_WIDTH-1:0] operandB,
    input  wire logic [8:0]                    immediate,
    input  wire logic                          useImmediate,
    input  wire logic [isaPkg::PC_WIDTH-1:0]   npc,
    output      logic [busPkg::DATA_WIDTH-1:0] result,
    output      logic                          isZero,
    output      logic [isaPkg::PC_WIDTH-1:0]   branchTarget
);

    logic [busPkg::DATA_WIDTH-1:0] immExt; // sign-extended immediate
    logic [busPkg::DATA_WIDTH-1:0] opB;    // second operand after mux

    // sign bit copied over the upper byte, low 8 bits kept
    assign immExt = {{(busPkg::DATA_WIDTH - 8){immediate[8]}}, immediate[7:0]};
    assign opB    = useImmediate ? immExt : operandB;

    always_comb begin
        case (op)
            isaPkg::ALU_ADD: result = operandA + opB;
            isaPkg::ALU_SUB: result = operandA - opB;
            isaPkg::ALU_AND: result = operandA & opB;
            isaPkg::ALU_OR:  result = operandA | opB;
            isaPkg::ALU_XOR: result = operandA ^ opB;
            isaPkg::ALU_SRL: result = {1'b0, operandA[busPkg::DATA_WIDTH-1:1]}; // logical
            default:         result = operandA; // pass, used by branch and no-ops
        endcase
    end

    // BEQZ condition
    assign isZero = (operandA == '0);

    // halfword offset from npc, wraps in 12 bits
    assign branchTarget = npc + {immExt[isaPkg::PC_WIDTH-2:0], 1'b0};

endmodule

`default_nettype wire

//--- hdl/apbMaster.sv
// APB master for the core's single outstanding memory request
// setup phase on the request cycle, access phase until pready
`timescale 1ns/1ps
`default_nettype none

module apbMaster (
    input  wire logic                          clock,
    input  wire logic                          rst,
    input  wire logic                          memReq,
    input  wire logic                          memWrite,
    input  wire logic [busPkg::ADDR_WIDTH-1:0] memAddr,
    input  wire logic [busPkg::DATA_WIDTH-1:0] memWdata,
    output      logic [busPkg::DATA_WIDTH-1:0] memRdata,
    output      logic                          memDone,
    output      logic [busPkg::ADDR_WIDTH-1:0] paddr,
    output      logic                          psel,
    output      logic                          penable,
    output      logic                          pwrite,
    output      logic [busPkg::DATA_WIDTH-1:0] pwdata,
    input  wire logic [busPkg::DATA_WIDTH-1:0] prdata,
    input  wire logic                          pready
);

    // three phases: idle, setup (request cycle), access (busy)
    logic busy;        // access phase in progress
    logic setupPhase;
    logic accessPhase;

    // request captured in setup, replayed during access
    logic [busPkg::ADDR_WIDTH-1:0] addrQ;
    logic                          writeQ;
    logic [busPkg::DATA_WIDTH-1:0] wdataQ;

    assign setupPhase  = memReq & ~busy; // core never requests while busy
    assign accessPhase = busy;

    always_ff @(posedge clock) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (setupPhase) begin
            busy <= 1'b1;
        end else if (accessPhase && pready) begin
            busy <= 1'b0; // transfer ends, back to idle
        end
    end

    always_ff @(posedge clock) begin
        if (setupPhase) begin
            addrQ  <= memAddr;
            writeQ <= memWrite;
            wdataQ <= memWdata;
        end
    end

    // bus outputs, stable from setup until pready
    assign psel    = setupPhase | accessPhase;
    assign penable = accessPhase;
    assign paddr   = accessPhase ? addrQ : memAddr;
    assign pwrite  = accessPhase ? writeQ : (setupPhase & memWrite); // low when idle
    assign pwdata  = accessPhase ? wdataQ : memWdata;

    // completion back to the core
    assign memDone  = accessPhase & pready; // one cycle pulse
    assign memRdata = prdata;               // sampled by core with memDone

endmodule

`default_nettype wire

//--- hdl/busPkg.sv
// data path and APB bus widths
`default_nettype none

package busPkg;

    // register and memory word
    localparam int DATA_WIDTH = 16;

    // APB address, same width as the ALU result
    // byte address, data memory is word organised by the slave
    localparam int ADDR_WIDTH = 16;

endpackage

`default_nettype wire

//--- hdl/isaPkg.sv
// ISA definitions for the 16-bit multi-cycle core
// instruction formats, opcodes, function codes, core states, ALU ops
`default_nettype none

package isaPkg;

    localparam int PC_WIDTH = 12; // program counter width

    // major opcodes, top 3 bits of every instruction
    localparam logic [2:0] OP_LW    = 3'd0;
    localparam logic [2:0] OP_SW    = 3'd1;
    localparam logic [2:0] OP_BEQZ  = 3'd2;
    localparam logic [2:0] OP_ALUOP = 3'd3; // register-register group
    localparam logic [2:0] OP_ADDI  = 3'd4;
    localparam logic [2:0] OP_SUBI  = 3'd5;
    // opcodes 6 and 7 unused, run as no-ops

    // function field of OP_ALUOP
    localparam logic [6:0] FN_ADD = 7'd0;
    localparam logic [6:0] FN_SUB = 7'd1;
    localparam logic [6:0] FN_AND = 7'd2;
    localparam logic [6:0] FN_OR  = 7'd3;
    localparam logic [6:0] FN_XOR = 7'd4;
    localparam logic [6:0] FN_SRL = 7'd5; // shift src1 right by one

    // register-register layout, msb first
    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] src1;
        logic [1:0] src2;
        logic [1:0] dest;
        logic [6:0] funct;
    } rFormatFields;

    // immediate layout, dest sits where rFormat has src2
    typedef struct packed {
        logic [2:0] opcode;
        logic [1:0] src1;
        logic [1:0] dest;
        logic [8:0] imm;   // sign bit 8
    } iFormatFields;

    // one instruction word, two views
    typedef union packed {
        rFormatFields rFormat;
        iFormatFields iFormat;
    } instrWord;

    // multi-cycle sequencing
    typedef enum logic [2:0] {
        ST_IF,  // fetch
        ST_ID,  // decode, operand read
        ST_EX,  // execute
        ST_MEM, // memory access, pc update
        ST_WB   // write-back
    } coreState;

    // operation select for the ALU
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SRL,
        ALU_PASS // operand A unchanged
    } aluOp;

endpackage

`default_nettype wire

//--- hdl/regFile.sv
// four-entry register file
// two combinational read ports, one synchronous write port
// entry 0 is never written and reads as zero
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire logic                          clock,
    input  wire logic                          rst,
    input  wire logic [1:0]                    readAddrA,
    input  wire logic [1:0]                    readAddrB,
    output      logic [busPkg::DATA_WIDTH-1:0] readDataA,
    output      logic [busPkg::DATA_WIDTH-1:0] readDataB,
    input  wire logic                          writeEnable,
    input  wire logic [1:0]                    writeAddr,
    input  wire logic [busPkg::DATA_WIDTH-1:0] writeData
);

    logic [busPkg::DATA_WIDTH-1:0] regs [0:3]; // R0..R3

    // write port, R0 writes dropped
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != 2'd0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // read ports, no bypass needed (write in WB, read in ID)
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

//--- hdl/vsaCore.sv
// multi-cycle 16-bit core
// five-state FSM with IR, NPC, A, B, ALU output, condition and load data registers
// memory access through a request/done handshake
`timescale 1ns/1ps
`default_nettype none

module vsaCore (
    input  wire logic                          clock,
    input  wire logic                          rst,
    output      logic [isaPkg::PC_WIDTH-1:0]   pc,
    input  wire logic [busPkg::DATA_WIDTH-1:0] instruction,
    output      logic                          memReq,
    output      logic                          memWrite,
    output      logic [busPkg::ADDR_WIDTH-1:0] memAddr,
    output      logic [busPkg::DATA_WIDTH-1:0] memWdata,
    input  wire logic [busPkg::DATA_WIDTH-1:0] memRdata,
    input  wire logic                          memDone
);

    isaPkg::coreState state;

    // datapath registers
    isaPkg::instrWord              ir;     // instruction register
    logic [isaPkg::PC_WIDTH-1:0]   npc;    // pc + 2
    logic [busPkg::DATA_WIDTH-1:0] regA;   // first operand
    logic [busPkg::DATA_WIDTH-1:0] regB;   // second operand, store data
    logic [busPkg::DATA_WIDTH-1:0] aluOut; // result, address or target
    logic                          cond;   // A was zero
    logic [busPkg::DATA_WIDTH-1:0] lmd;    // load data
    logic                          memStart; // first cycle of MEM

    // decode
    logic [2:0] opcode;
    logic       isLoad;
    logic       isStore;
    logic       isMemRef;
    logic       isBranch;
    logic       isRegAlu;
    logic       isImmAlu;
    logic       fnValid;      // known function code
    logic       useImmediate;
    logic       memPhaseDone; // MEM may end this cycle
    isaPkg::aluOp aluSel;

    // regfile and ALU hookup
    logic [busPkg::DATA_WIDTH-1:0] readDataA;
    logic [busPkg::DATA_WIDTH-1:0] readDataB;
    logic                          writeEnable;
    logic [1:0]                    writeAddr;
    logic [busPkg::DATA_WIDTH-1:0] writeData;
    logic [busPkg::DATA_WIDTH-1:0] aluResult;
    logic                          aluZero;
    logic [isaPkg::PC_WIDTH-1:0]   branchTarget;

    assign opcode   = ir.iFormat.opcode; // same bits in both views
    assign isLoad   = (opcode == isaPkg::OP_LW);
    assign isStore  = (opcode == isaPkg::OP_SW);
    assign isMemRef = isLoad | isStore;
    assign isBranch = (opcode == isaPkg::OP_BEQZ);
    assign isRegAlu = (opcode == isaPkg::OP_ALUOP);
    assign isImmAlu = (opcode == isaPkg::OP_ADDI) | (opcode == isaPkg::OP_SUBI);

    // ALU operation from opcode, or function field for register ops
    always_comb begin
        aluSel       = isaPkg::ALU_PASS;
        useImmediate = 1'b0;
        fnValid      = 1'b0;
        case (opcode)
            isaPkg::OP_LW, isaPkg::OP_SW, isaPkg::OP_ADDI: begin
                aluSel       = isaPkg::ALU_ADD; // address or sum
                useImmediate = 1'b1;
            end
            isaPkg::OP_SUBI: begin
                aluSel       = isaPkg::ALU_SUB;
                useImmediate = 1'b1;
            end
            isaPkg::OP_ALUOP: begin
                fnValid = 1'b1;
                case (ir.rFormat.funct)
                    isaPkg::FN_ADD: aluSel = isaPkg::ALU_ADD;
                    isaPkg::FN_SUB: aluSel = isaPkg::ALU_SUB;
                    isaPkg::FN_AND: aluSel = isaPkg::ALU_AND;
                    isaPkg::FN_OR:  aluSel = isaPkg::ALU_OR;
                    isaPkg::FN_XOR: aluSel = isaPkg::ALU_XOR;
                    isaPkg::FN_SRL: aluSel = isaPkg::ALU_SRL;
                    default:        fnValid = 1'b0; // no-op, nothing written
                endcase
            end
            default: ; // BEQZ and opcodes 6, 7 pass A
        endcase
    end

    regFile i_regFile (
        .clock       (clock),
        .rst         (rst),
        .readAddrA   (ir.rFormat.src1),
        .readAddrB   (ir.rFormat.src2), // also I-format dest, SW data
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData)
    );

    aluUnit i_aluUnit (
        .op           (aluSel),
        .operandA     (regA),
        .operandB     (regB),
        .immediate    (ir.iFormat.imm),
        .useImmediate (useImmediate),
        .npc          (npc),
        .result       (aluResult),
        .isZero       (aluZero),
        .branchTarget (branchTarget)
    );

    // memory side, held stable for the whole MEM state
    assign memReq   = memStart & isMemRef; // pulse on MEM entry
    assign memWrite = isStore;
    assign memAddr  = aluOut;
    assign memWdata = regB;

    // non-memory ops leave MEM after one cycle
    assign memPhaseDone = ~isMemRef | memDone;

    // write-back port
    assign writeEnable = (state == isaPkg::ST_WB) & ((isRegAlu & fnValid) | isImmAlu | isLoad);
    assign writeAddr   = isRegAlu ? ir.rFormat.dest : ir.iFormat.dest;
    assign writeData   = isLoad ? lmd : aluOut;

    // control state
    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= isaPkg::ST_IF;
            pc       <= '0;
            memStart <= 1'b0;
        end else begin
            memStart <= (state == isaPkg::ST_EX); // EX always goes to MEM
            case (state)
                isaPkg::ST_IF:  state <= isaPkg::ST_ID;
                isaPkg::ST_ID:  state <= isaPkg::ST_EX;
                isaPkg::ST_EX:  state <= isaPkg::ST_MEM;
                isaPkg::ST_MEM: begin
                    if (memPhaseDone) begin
                        state <= isaPkg::ST_WB;
                        // taken branch or fall through
                        pc <= (isBranch && cond) ? aluOut[isaPkg::PC_WIDTH-1:0] : npc;
                    end
                end
                default: state <= isaPkg::ST_IF; // WB and illegal codes
            endcase
        end
    end

    // payload registers, loaded per state
    always_ff @(posedge clock) begin
        case (state)
            isaPkg::ST_IF: begin
                ir  <= instruction;
                npc <= pc + isaPkg::PC_WIDTH'(2);
            end
            isaPkg::ST_ID: begin
                regA <= readDataA;
                regB <= readDataB;
            end
            isaPkg::ST_EX: begin
                // branch keeps its target here until MEM
                aluOut <= isBranch
                        ? {{(busPkg::DATA_WIDTH - isaPkg::PC_WIDTH){1'b0}}, branchTarget}
                        : aluResult;
                cond   <= aluZero;
            end
            isaPkg::ST_MEM: begin
                if (memDone && isLoad) begin
                    lmd <= memRdata; // valid only with done
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/vsaSystem.sv
// top level of the processor system
// core plus APB master, instruction port and APB data port
`timescale 1ns/1ps
`default_nettype none

module vsaSystem (
    input  wire logic                          clock,
    input  wire logic                          rst,
    output      logic [isaPkg::PC_WIDTH-1:0]   pc,
    input  wire logic [busPkg::DATA_WIDTH-1:0] instruction,
    output      logic [busPkg::ADDR_WIDTH-1:0] paddr,
    output      logic                          psel,
    output      logic                          penable,
    output      logic                          pwrite,
    output      logic [busPkg::DATA_WIDTH-1:0] pwdata,
    input  wire logic [busPkg::DATA_WIDTH-1:0] prdata,
    input  wire logic                          pready
);

    // core to master handshake
    logic                          memReq;
    logic                          memWrite;
    logic [busPkg::ADDR_WIDTH-1:0] memAddr;
    logic [busPkg::DATA_WIDTH-1:0] memWdata;
    logic [busPkg::DATA_WIDTH-1:0] memRdata;
    logic                          memDone;

    vsaCore i_vsaCore (
        .clock       (clock),
        .rst         (rst),
        .pc          (pc),
        .instruction (instruction),
        .memReq      (memReq),
        .memWrite    (memWrite),
        .memAddr     (memAddr),
        .memWdata    (memWdata),
        .memRdata    (memRdata),
        .memDone     (memDone)
    );

    apbMaster i_apbMaster (
        .clock    (clock),
        .rst      (rst),
        .memReq   (memReq),
        .memWrite (memWrite),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRdata (memRdata),
        .memDone  (memDone),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready)
    );

endmodule

`default_nettype wire

//--- project.f
hdl/isaPkg.sv
hdl/busPkg.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/vsaCore.sv
hdl/apbMaster.sv
hdl/vsaSystem.sv
bench/vsaTbMem.sv
bench/vsaTb.sv
